//--- src/i3c_target_pkg.sv
// ================================================
// Shared types and constants of the I3C target sequencer
// All records are packed so they travel as one vector
// The header union is 8 bits and holds one bus byte
// ================================================

package i3c_target_pkg;

  // One bus byte
  typedef logic [7:0] byte_t;

  // 7-bit bus address
  typedef logic [6:0] addr7_t;

  // Address header as it appears on the bus, MSB first
  typedef struct packed {
    addr7_t addr;
    logic   rnw;
  } addr_hdr_t;

  // A received byte is read as a header or as a command code
  typedef union packed {
    addr_hdr_t hdr;
    byte_t     ccc;
  } i3c_hdr_u;

  // Per-slot address configuration
  // Dynamic address wins over static when both are valid
  typedef struct packed {
    addr7_t dyn_addr;
    logic   dyn_valid;
    addr7_t sta_addr;
    logic   sta_valid;
  } addr_cfg_t;

  // Receive requests to the bus layer, held as levels
  typedef struct packed {
    logic req_byte;
    logic req_bit;
  } rx_req_t;

  // Transmit requests to the bus layer
  // A bit transfer uses value bit 0 only
  typedef struct packed {
    logic  req_byte;
    logic  req_bit;
    byte_t value;
  } tx_req_t;

  // Broadcast header 0x7E with write direction
  localparam byte_t RSVD_HDR = 8'hFC;

  // SDA value driven for an ACK
  localparam logic ACK_BIT = 1'b0;

endpackage : i3c_target_pkg

//--- src/i3c_header_decoder.sv
// ================================================
// Captures header bytes while the sequencer expects one
// hdr_valid_o pulses one cycle after the byte's rx done
// ================================================

`timescale 1ns/1ps

module i3c_header_decoder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rx_done_i,
  input  i3c_target_pkg::byte_t    rx_data_i,
  input  logic                     hdr_expect_i,
  input  logic                     start_any_i,
  output i3c_target_pkg::i3c_hdr_u hdr_o,
  output logic                     hdr_valid_o,
  output i3c_target_pkg::byte_t    last_addr_o,
  output logic                     last_addr_valid_o
);

  logic capture;

  // A header arrives when a byte completes during a header request
  assign capture = rx_done_i & hdr_expect_i;

  // Header byte register
  // Held until the next header so later stages can read it
  always_ff @(posedge clk_i) begin
    if (capture) begin
      hdr_o.ccc <= rx_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hdr_valid_o       <= 1'b0;
      last_addr_valid_o <= 1'b0;
    end else begin
      // One-cycle strobe to every address slot
      hdr_valid_o <= capture;
      // Last address is stale once a new START begins
      if (start_any_i) begin
        last_addr_valid_o <= 1'b0;
      end else if (capture) begin
        last_addr_valid_o <= 1'b1;
      end
    end
  end

  // Last header as address plus direction bit
  assign last_addr_o = {hdr_o.hdr.addr, hdr_o.hdr.rnw};

endmodule : i3c_header_decoder

//--- src/i3c_addr_slot.sv
// ================================================
// One address slot of the target
// A slot without a valid address never hits
// The direction bit is ignored by the compare
// ================================================

`timescale 1ns/1ps

module i3c_addr_slot (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  i3c_target_pkg::addr_cfg_t cfg_i,
  input  i3c_target_pkg::i3c_hdr_u  hdr_i,
  input  logic                      hdr_valid_i,
  output logic                      hit_o,
  output logic                      hit_valid_o
);

  logic hit_d;

  // Dynamic address takes precedence over the static one
  always_comb begin
    if (cfg_i.dyn_valid) begin
      hit_d = (cfg_i.dyn_addr == hdr_i.hdr.addr);
    end else if (cfg_i.sta_valid) begin
      hit_d = (cfg_i.sta_addr == hdr_i.hdr.addr);
    end else begin
      hit_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      hit_o       <= 1'b0;
      hit_valid_o <= 1'b0;
    end else begin
      // Result and strobe move together, one cycle after the header
      hit_valid_o <= hdr_valid_i;
      if (hdr_valid_i) begin
        hit_o <= hit_d;
      end
    end
  end

endmodule : i3c_addr_slot

//--- src/i3c_addr_select.sv
// ================================================
// Picks the lowest hitting slot for each header
// Slot 0 is the primary device, higher slots are virtual
// The broadcast header never updates the slot selection
// ================================================

`timescale 1ns/1ps

module i3c_addr_select #(
  parameter  int unsigned NUM_SLOTS = 2,
  localparam int unsigned SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [NUM_SLOTS-1:0]     hits_i,
  input  logic                     hit_valid_i,
  input  i3c_target_pkg::i3c_hdr_u hdr_i,
  input  logic                     idle_i,
  output logic                     match_o,
  output logic                     rsvd_o,
  output logic                     match_valid_o,
  output logic [SLOT_W-1:0]        sel_slot_o,
  output logic                     xfer_in_progress_o
);

  import i3c_target_pkg::*;

  logic              rsvd_d;
  logic              match_d;
  logic [SLOT_W-1:0] sel_d;

  // Broadcast header is compared as a whole byte
  assign rsvd_d  = (hdr_i.ccc == RSVD_HDR);
  assign match_d = (|hits_i) & ~rsvd_d;

  // Walk down so the lowest index is the last one written
  always_comb begin
    sel_d = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (hits_i[i]) begin
        sel_d = SLOT_W'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      match_o            <= 1'b0;
      rsvd_o             <= 1'b0;
      match_valid_o      <= 1'b0;
      sel_slot_o         <= '0;
      xfer_in_progress_o <= 1'b0;
    end else begin
      match_valid_o <= hit_valid_i;
      // Decision stays stable until the next header
      if (hit_valid_i) begin
        match_o <= match_d;
        rsvd_o  <= rsvd_d;
        if (!rsvd_d) begin
          sel_slot_o <= sel_d;
        end
      end
      // Transfer flag lives from the first match until idle
      if (idle_i) begin
        xfer_in_progress_o <= 1'b0;
      end else if (hit_valid_i && match_d) begin
        xfer_in_progress_o <= 1'b1;
      end
    end
  end

endmodule : i3c_addr_select

//--- src/i3c_target_seq.sv
// ================================================
// Transaction FSM of the target with write, read and CCC paths
// A STOP returns to idle on the next cycle from any state
// The RX FIFO slot is single, back-pressure must end within a byte
// ================================================

`timescale 1ns/1ps

module i3c_target_seq (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     target_enable_i,
  input  logic                     bus_start_i,
  input  logic                     bus_rstart_i,
  input  logic                     bus_stop_i,
  input  logic                     rx_done_i,
  input  i3c_target_pkg::byte_t    rx_data_i,
  input  logic                     tx_done_i,
  input  logic                     match_i,
  input  logic                     rsvd_i,
  input  logic                     match_valid_i,
  input  i3c_target_pkg::i3c_hdr_u hdr_i,
  input  logic                     rx_fifo_wready_i,
  input  logic                     tx_fifo_rvalid_i,
  input  i3c_target_pkg::byte_t    tx_fifo_rdata_i,
  input  logic                     tx_last_byte_i,
  input  logic                     ccc_done_i,
  input  logic                     ccc_next_i,
  output i3c_target_pkg::rx_req_t  rx_req_o,
  output i3c_target_pkg::tx_req_t  tx_req_o,
  output logic                     hdr_expect_o,
  output logic                     start_any_o,
  output logic                     idle_o,
  output logic                     rx_fifo_wvalid_o,
  output i3c_target_pkg::byte_t    rx_fifo_wdata_o,
  output logic                     tx_fifo_rready_o,
  output i3c_target_pkg::byte_t    ccc_o,
  output logic                     ccc_valid_o,
  output logic                     parity_err_o,
  output logic                     event_nack_o,
  output logic                     transmitting_o
);

  import i3c_target_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_F_RX,
    ST_F_CHECK,
    ST_F_ACK,
    ST_S_RX,
    ST_S_CHECK,
    ST_S_ACK,
    ST_WR_DATA,
    ST_WR_TBIT,
    ST_RD_DATA,
    ST_RD_TBIT,
    ST_WAIT,
    ST_CCC
  } state_e;

  state_e state_q;
  state_e state_d;
  state_e data_st;
  logic   rstart_q;
  logic   last_q;
  byte_t  data_q;
  byte_t  tx_byte_q;
  logic   tbit_ok;
  logic   push;

  assign start_any_o = bus_start_i | bus_rstart_i;

  // Odd parity over data byte and T-bit
  assign tbit_ok = (rx_data_i[0] == ~^data_q);
  assign push    = (state_q == ST_WR_TBIT) & rx_done_i & tbit_ok;

  // Data phase after an ACK, from the header direction bit
  // An empty TX FIFO on a read leaves the bus alone
  always_comb begin
    if (!hdr_i.hdr.rnw) begin
      data_st = ST_WR_DATA;
    end else if (tx_fifo_rvalid_i) begin
      data_st = ST_RD_DATA;
    end else begin
      data_st = ST_WAIT;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:    if (target_enable_i && start_any_o) state_d = ST_F_RX;
      ST_F_RX:    if (rx_done_i) state_d = ST_F_CHECK;
      ST_F_CHECK: begin
        if (match_valid_i) state_d = (match_i || rsvd_i) ? ST_F_ACK : ST_WAIT;
      end
      ST_F_ACK:   if (tx_done_i) state_d = rsvd_i ? ST_S_RX : data_st;
      // Code byte goes to the CCC engine, a header after Sr is checked
      ST_S_RX:    if (rx_done_i) state_d = rstart_q ? ST_S_CHECK : ST_CCC;
      ST_S_CHECK: if (match_valid_i) state_d = match_i ? ST_S_ACK : ST_WAIT;
      ST_S_ACK:   if (tx_done_i) state_d = data_st;
      ST_WR_DATA: begin
        if (start_any_o) state_d = ST_F_RX;
        else if (rx_done_i) state_d = ST_WR_TBIT;
      end
      ST_WR_TBIT: begin
        if (start_any_o) state_d = ST_F_RX;
        else if (rx_done_i) state_d = ST_WR_DATA;
      end
      ST_RD_DATA: begin
        if (start_any_o) state_d = ST_F_RX;
        else if (tx_done_i) state_d = ST_RD_TBIT;
      end
      ST_RD_TBIT: begin
        if (start_any_o) begin
          state_d = ST_F_RX;
        end else if (tx_done_i) begin
          state_d = (last_q || !tx_fifo_rvalid_i) ? ST_WAIT : ST_RD_DATA;
        end
      end
      ST_WAIT:    if (start_any_o) state_d = ST_F_RX;
      ST_CCC: begin
        if (ccc_done_i) state_d = ST_IDLE;
        else if (ccc_next_i) state_d = ST_S_RX;
      end
      default:    state_d = ST_IDLE;
    endcase
    // STOP ends every transfer
    if (bus_stop_i) state_d = ST_IDLE;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q          <= ST_IDLE;
      rstart_q         <= 1'b0;
      last_q           <= 1'b0;
      rx_fifo_wvalid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      // Sr seen while waiting for the second byte
      if (state_q != ST_S_RX) begin
        rstart_q <= 1'b0;
      end else if (start_any_o) begin
        rstart_q <= 1'b1;
      end
      // Last flag belongs to the popped byte
      if (tx_fifo_rready_o) begin
        last_q <= tx_last_byte_i;
      end
      // Hold valid under back-pressure, a new push keeps it high
      if (push) begin
        rx_fifo_wvalid_o <= 1'b1;
      end else if (rx_fifo_wready_i) begin
        rx_fifo_wvalid_o <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_WR_DATA) && rx_done_i) data_q <= rx_data_i;
    if (push) rx_fifo_wdata_o <= data_q;
    if (tx_fifo_rready_o) tx_byte_q <= tx_fifo_rdata_i;
    if ((state_q == ST_S_RX) && !rstart_q && rx_done_i) ccc_o <= rx_data_i;
  end

  // Bus requests per state
  // Receive requests drop during a START pulse
  always_comb begin
    rx_req_o = '0;
    tx_req_o = '0;
    case (state_q)
      ST_F_RX, ST_S_RX, ST_WR_DATA: rx_req_o.req_byte = ~start_any_o;
      ST_WR_TBIT: rx_req_o.req_bit = ~start_any_o;
      ST_F_ACK, ST_S_ACK: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = {7'b0, ACK_BIT};
      end
      ST_RD_DATA: begin
        tx_req_o.req_byte = 1'b1;
        tx_req_o.value    = tx_byte_q;
      end
      // T-bit high announces more data
      ST_RD_TBIT: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = {7'b0, ~last_q};
      end
      default: ;
    endcase
  end

  // Pop once on each entry to the read data state
  assign tx_fifo_rready_o = (state_d == ST_RD_DATA) && (state_q != ST_RD_DATA);

  // Only real headers go to the decoder, never a CCC code
  assign hdr_expect_o = (state_q == ST_F_RX) || ((state_q == ST_S_RX) && rstart_q);

  // Nobody claimed the header
  assign event_nack_o = match_valid_i && !match_i &&
                        (((state_q == ST_F_CHECK) && !rsvd_i) || (state_q == ST_S_CHECK));

  assign parity_err_o   = (state_q == ST_WR_TBIT) && rx_done_i && !tbit_ok;
  assign ccc_valid_o    = (state_q == ST_CCC);
  assign idle_o         = (state_q == ST_IDLE);
  assign transmitting_o = state_q inside {ST_F_ACK, ST_S_ACK, ST_RD_DATA, ST_RD_TBIT};

endmodule : i3c_target_seq

//--- src/i3c_target_top.sv
// ================================================
// I3C target sequencer top level
// NUM_SLOTS sets the address slots, slot 0 is the primary device
// ================================================

`timescale 1ns/1ps

module i3c_target_top #(
  parameter  int unsigned NUM_SLOTS = 2,
  localparam int unsigned SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      target_enable_i,
  input  i3c_target_pkg::addr_cfg_t [NUM_SLOTS-1:0] slot_cfg_i,
  // Bus detectors
  input  logic                                      bus_start_i,
  input  logic                                      bus_rstart_i,
  input  logic                                      bus_stop_i,
  // Bus receive and transmit layer
  output i3c_target_pkg::rx_req_t                   rx_req_o,
  input  logic                                      rx_done_i,
  input  i3c_target_pkg::byte_t                     rx_data_i,
  output i3c_target_pkg::tx_req_t                   tx_req_o,
  input  logic                                      tx_done_i,
  // RX and TX FIFOs
  output logic                                      rx_fifo_wvalid_o,
  output i3c_target_pkg::byte_t                     rx_fifo_wdata_o,
  input  logic                                      rx_fifo_wready_i,
  input  logic                                      tx_fifo_rvalid_i,
  output logic                                      tx_fifo_rready_o,
  input  i3c_target_pkg::byte_t                     tx_fifo_rdata_i,
  input  logic                                      tx_last_byte_i,
  // CCC engine
  output i3c_target_pkg::byte_t                     ccc_o,
  output logic                                      ccc_valid_o,
  input  logic                                      ccc_done_i,
  input  logic                                      ccc_next_i,
  // Status and events
  output logic                                      idle_o,
  output logic                                      transmitting_o,
  output logic                                      parity_err_o,
  output logic                                      event_nack_o,
  output logic [SLOT_W-1:0]                         sel_slot_o,
  output logic                                      xfer_in_progress_o,
  output i3c_target_pkg::byte_t                     last_addr_o,
  output logic                                      last_addr_valid_o
);

  import i3c_target_pkg::*;

  i3c_hdr_u             hdr;
  logic                 hdr_valid;
  logic                 hdr_expect;
  logic                 start_any;
  logic [NUM_SLOTS-1:0] hits;
  logic                 hit_valid;
  logic                 match;
  logic                 rsvd;
  logic                 match_valid;

  i3c_header_decoder u_decoder (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rx_done_i         (rx_done_i),
    .rx_data_i         (rx_data_i),
    .hdr_expect_i      (hdr_expect),
    .start_any_i       (start_any),
    .hdr_o             (hdr),
    .hdr_valid_o       (hdr_valid),
    .last_addr_o       (last_addr_o),
    .last_addr_valid_o (last_addr_valid_o)
  );

  // All slots decide in the same cycle, slot 0 supplies the strobe
  for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
    if (i == 0) begin : g_primary
      i3c_addr_slot u_slot (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cfg_i       (slot_cfg_i[i]),
        .hdr_i       (hdr),
        .hdr_valid_i (hdr_valid),
        .hit_o       (hits[i]),
        .hit_valid_o (hit_valid)
      );
    end else begin : g_virtual
      i3c_addr_slot u_slot (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cfg_i       (slot_cfg_i[i]),
        .hdr_i       (hdr),
        .hdr_valid_i (hdr_valid),
        .hit_o       (hits[i]),
        .hit_valid_o ()
      );
    end
  end

  i3c_addr_select #(
    .NUM_SLOTS (NUM_SLOTS)
  ) u_select (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .hits_i             (hits),
    .hit_valid_i        (hit_valid),
    .hdr_i              (hdr),
    .idle_i             (idle_o),
    .match_o            (match),
    .rsvd_o             (rsvd),
    .match_valid_o      (match_valid),
    .sel_slot_o         (sel_slot_o),
    .xfer_in_progress_o (xfer_in_progress_o)
  );

  i3c_target_seq u_seq (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .target_enable_i  (target_enable_i),
    .bus_start_i      (bus_start_i),
    .bus_rstart_i     (bus_rstart_i),
    .bus_stop_i       (bus_stop_i),
    .rx_done_i        (rx_done_i),
    .rx_data_i        (rx_data_i),
    .tx_done_i        (tx_done_i),
    .match_i          (match),
    .rsvd_i           (rsvd),
    .match_valid_i    (match_valid),
    .hdr_i            (hdr),
    .rx_fifo_wready_i (rx_fifo_wready_i),
    .tx_fifo_rvalid_i (tx_fifo_rvalid_i),
    .tx_fifo_rdata_i  (tx_fifo_rdata_i),
    .tx_last_byte_i   (tx_last_byte_i),
    .ccc_done_i       (ccc_done_i),
    .ccc_next_i       (ccc_next_i),
    .rx_req_o         (rx_req_o),
    .tx_req_o         (tx_req_o),
    .hdr_expect_o     (hdr_expect),
    .start_any_o      (start_any),
    .idle_o           (idle_o),
    .rx_fifo_wvalid_o (rx_fifo_wvalid_o),
    .rx_fifo_wdata_o  (rx_fifo_wdata_o),
    .tx_fifo_rready_o (tx_fifo_rready_o),
    .ccc_o            (ccc_o),
    .ccc_valid_o      (ccc_valid_o),
    .parity_err_o     (parity_err_o),
    .event_nack_o     (event_nack_o),
    .transmitting_o   (transmitting_o)
  );

endmodule : i3c_target_top

//--- bench/i3c_target_assertions.sv
// ==================================================
// Protocol checks bound into the target sequencer
// Inactive while reset is asserted
// ==================================================

`timescale 1ns/1ps

module i3c_target_assertions (
  input logic                    clk_i,
  input logic                    rst_ni,
  input i3c_target_pkg::rx_req_t rx_req_o,
  input i3c_target_pkg::tx_req_t tx_req_o,
  input logic                    rx_fifo_wvalid_o,
  input i3c_target_pkg::byte_t   rx_fifo_wdata_o,
  input logic                    rx_fifo_wready_i,
  input logic                    tx_fifo_rready_o,
  input logic                    tx_fifo_rvalid_i
);

  // Write data stays offered and unchanged until the FIFO takes it
  wvalid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_fifo_wvalid_o && !rx_fifo_wready_i |=> rx_fifo_wvalid_o && $stable(rx_fifo_wdata_o))
    else $error("RX FIFO write dropped or changed before ready");

  // A pop is one cycle wide and only from a non-empty FIFO
  rready_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_fifo_rready_o |-> tx_fifo_rvalid_i && !$past(tx_fifo_rready_o))
    else $error("TX FIFO pop lasted two cycles or hit an empty FIFO");

  // Bus layer never gets receive and transmit at once
  req_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !((rx_req_o.req_byte || rx_req_o.req_bit) && (tx_req_o.req_byte || tx_req_o.req_bit)))
    else $error("receive and transmit requested together");

endmodule : i3c_target_assertions

bind i3c_target_seq i3c_target_assertions u_assertions (.*);

//--- bench/tb_i3c_target.sv
// ==================================================
// Testbench for the I3C target sequencer, two slots
// Emulates bus layer, FIFOs and CCC engine in software
// Single-slot RX FIFO model, wready low at most one cycle
// ==================================================

`timescale 1ns/1ps

module tb_i3c_target;

  import i3c_target_pkg::*;

  localparam int TMO = 200;

  // One transaction row, bytes packed MSB first in data
  typedef struct {
    string           name;
    addr_cfg_t [1:0] cfg;
    byte_t           hdr;
    logic            sr_en;
    byte_t           sr_hdr;
    int              nbytes;
    logic [31:0]     data;
    int              bad_idx;
    logic            exp_nack;
    int              exp_slot;
    logic            ccc_en;
    byte_t           ccc;
  } row_t;

  localparam addr_cfg_t S0_DYN = '{dyn_addr: 7'h12, dyn_valid: 1'b1,
                                   sta_addr: 7'h50, sta_valid: 1'b1};
  localparam addr_cfg_t S0_STA = '{dyn_addr: 7'h12, dyn_valid: 1'b0,
                                   sta_addr: 7'h50, sta_valid: 1'b1};
  localparam addr_cfg_t S0_OFF = '{dyn_addr: 7'h12, dyn_valid: 1'b0,
                                   sta_addr: 7'h50, sta_valid: 1'b0};
  localparam addr_cfg_t S1_DYN = '{dyn_addr: 7'h34, dyn_valid: 1'b1,
                                   sta_addr: 7'h00, sta_valid: 1'b0};

  logic clk_i = 1'b0;
  logic rst_ni, target_enable_i, bus_start_i, bus_rstart_i, bus_stop_i;
  logic rx_done_i, tx_done_i, rx_fifo_wready_i, tx_fifo_rvalid_i, tx_last_byte_i;
  logic ccc_done_i, ccc_next_i;
  byte_t rx_data_i, tx_fifo_rdata_i, rx_fifo_wdata_o, ccc_o, last_addr_o;
  addr_cfg_t [1:0] slot_cfg_i;
  rx_req_t rx_req_o;
  tx_req_t tx_req_o;
  logic rx_fifo_wvalid_o, tx_fifo_rready_o, ccc_valid_o, idle_o, transmitting_o;
  logic parity_err_o, event_nack_o, xfer_in_progress_o, last_addr_valid_o;
  logic [0:0] sel_slot_o;

  integer seed = 28;
  integer bp_seed = 28;
  byte_t rx_got[$];
  byte_t tx_q[$];
  int nack_total = 0;
  int perr_total = 0;
  row_t rows[8];

  i3c_target_top #(.NUM_SLOTS(2)) UUT (.*);

  always #50 clk_i = ~clk_i;

  // RX FIFO sink with short back-pressure, plus event counters
  always @(posedge clk_i) begin
    if (!rx_fifo_wready_i) rx_fifo_wready_i <= 1'b1;
    else rx_fifo_wready_i <= (($random(bp_seed) & 3) != 0);
    if (rst_ni && rx_fifo_wvalid_o && rx_fifo_wready_i) rx_got.push_back(rx_fifo_wdata_o);
    if (rst_ni && event_nack_o) nack_total <= nack_total + 1;
    if (rst_ni && parity_err_o) perr_total <= perr_total + 1;
  end

  // TX FIFO source, pop accepts the head in the same cycle
  always @(posedge clk_i) begin
    if (tx_fifo_rready_o && tx_q.size() > 0) void'(tx_q.pop_front());
    tx_fifo_rvalid_i <= (tx_q.size() > 0);
    tx_fifo_rdata_i  <= (tx_q.size() > 0) ? tx_q[0] : 8'h00;
    tx_last_byte_i   <= (tx_q.size() == 1);
  end

  initial begin
    #2ms;
    $display("global watchdog expired, simulation hung");
    $display("FAIL: see errors above");
    $fatal(1);
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      abort_run("byte mismatch");
    end
  endtask

  task automatic check_slot(input string name, input logic [0:0] exp, input logic [0:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected slot %0d actual slot %0d", name, exp, act);
      abort_run("slot mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      abort_run("bit mismatch");
    end
  endtask

  // Kind 0 start, 1 repeated start, 2 stop, 3 CCC done
  task automatic drive_pulse(input int kind);
    @(posedge clk_i);
    bus_start_i  <= (kind == 0);
    bus_rstart_i <= (kind == 1);
    bus_stop_i   <= (kind == 2);
    ccc_done_i   <= (kind == 3);
    @(posedge clk_i);
    {bus_start_i, bus_rstart_i, bus_stop_i, ccc_done_i} <= '0;
  endtask

  task automatic wait_rx_req(input logic want_bit);
    bit seen;
    seen = 1'b0;
    for (int t = 0; t < TMO && !seen; t++) begin
      @(negedge clk_i);
      seen = want_bit ? rx_req_o.req_bit : rx_req_o.req_byte;
    end
    if (!seen) abort_run("timeout waiting for a receive request");
    check_bit("transmit flag during receive request", 1'b0, transmitting_o);
  endtask

  task automatic send_rx(input byte_t b, input logic is_bit);
    int gap;
    wait_rx_req(is_bit);
    gap = int'($unsigned($random(seed)) % 4);
    repeat (gap) @(posedge clk_i);
    @(posedge clk_i);
    rx_done_i <= 1'b1;
    rx_data_i <= b;
    @(posedge clk_i);
    rx_done_i <= 1'b0;
  endtask

  task automatic serve_tx(input logic is_bit, output byte_t val);
    bit seen;
    int gap;
    seen = 1'b0;
    for (int t = 0; t < TMO && !seen; t++) begin
      @(negedge clk_i);
      seen = is_bit ? tx_req_o.req_bit : tx_req_o.req_byte;
    end
    if (!seen) abort_run("timeout waiting for a transmit request");
    val = tx_req_o.value;
    check_bit("transmit flag during transmit request", 1'b1, transmitting_o);
    gap = int'($unsigned($random(seed)) % 4);
    repeat (gap) @(posedge clk_i);
    @(posedge clk_i);
    tx_done_i <= 1'b1;
    @(posedge clk_i);
    tx_done_i <= 1'b0;
  endtask

  task automatic wait_level(input int which, input string what);
    bit seen;
    seen = 1'b0;
    for (int t = 0; t < TMO && !seen; t++) begin
      @(negedge clk_i);
      case (which)
        0: seen = idle_o;
        1: seen = ccc_valid_o;
        default: seen = !rx_fifo_wvalid_o;
      endcase
    end
    if (!seen) abort_run({"timeout waiting for ", what});
  endtask

  task automatic run_row(input row_t r);
    int nack0, perr0, rx0, k;
    byte_t v, b, eff;
    bit seen;
    nack0 = nack_total;
    perr0 = perr_total;
    rx0   = rx_got.size();
    eff   = r.sr_en ? r.sr_hdr : r.hdr;
    @(posedge clk_i);
    slot_cfg_i <= r.cfg;
    if (eff[0]) begin
      for (int i = 0; i < r.nbytes; i++) tx_q.push_back(r.data[31-8*i -: 8]);
    end
    // Transfer flag of the previous row has dropped in idle
    @(negedge clk_i);
    check_bit({r.name, " xfer clear"}, 1'b0, xfer_in_progress_o);
    drive_pulse(0);
    send_rx(r.hdr, 1'b0);
    if (r.exp_nack) begin
      // No ACK may be requested before the unclaimed header is reported
      seen = 1'b0;
      for (int t = 0; t < TMO && !seen; t++) begin
        @(negedge clk_i);
        if (tx_req_o.req_bit || tx_req_o.req_byte) begin
          abort_run("ACK requested on unmatched header");
        end
        seen = event_nack_o;
      end
      if (!seen) abort_run("timeout waiting for the NACK event");
    end else begin
      serve_tx(1'b1, v);
      check_bit({r.name, " ack"}, 1'b0, v[0]);
      if (r.hdr == 8'hFC && r.ccc_en) begin
        send_rx(r.ccc, 1'b0);
        wait_level(1, "CCC valid");
        check_byte({r.name, " ccc"}, r.ccc, ccc_o);
        repeat (3) begin
          @(negedge clk_i);
          check_bit({r.name, " ccc held"}, 1'b1, ccc_valid_o);
        end
        drive_pulse(3);
        wait_level(0, "idle after CCC done");
      end else if (r.hdr == 8'hFC) begin
        wait_rx_req(1'b0);
        drive_pulse(1);
        send_rx(r.sr_hdr, 1'b0);
        serve_tx(1'b1, v);
        check_bit({r.name, " second ack"}, 1'b0, v[0]);
      end
      if (!r.ccc_en) begin
        for (int i = 0; i < r.nbytes; i++) begin
          b = r.data[31-8*i -: 8];
          if (eff[0]) begin
            serve_tx(1'b0, v);
            check_byte({r.name, " tx byte"}, b, v);
            serve_tx(1'b1, v);
            check_bit({r.name, " tbit"}, (i != r.nbytes - 1), v[0]);
          end else begin
            send_rx(b, 1'b0);
            send_rx({7'b0, (~^b) ^ (i == r.bad_idx)}, 1'b1);
          end
        end
      end
    end
    @(negedge clk_i);
    if (r.exp_slot >= 0) check_slot({r.name, " sel"}, 1'(r.exp_slot), sel_slot_o);
    check_bit({r.name, " xfer"}, !r.exp_nack && !r.ccc_en, xfer_in_progress_o);
    wait_level(2, "RX FIFO drain");
    drive_pulse(2);
    wait_level(0, "idle after STOP");
    check_byte({r.name, " last addr"}, eff, last_addr_o);
    check_bit({r.name, " last addr valid"}, 1'b1, last_addr_valid_o);
    check_bit({r.name, " nack event"}, r.exp_nack, nack_total != nack0);
    if (nack_total - nack0 > 1) abort_run({r.name, " NACK event pulsed more than once"});
    check_bit({r.name, " parity err"}, (r.bad_idx >= 0), perr_total != perr0);
    if (perr_total - perr0 > 1) abort_run({r.name, " parity error raised more than once"});
    k = rx0;
    for (int i = 0; i < r.nbytes && !eff[0] && !r.ccc_en && !r.exp_nack; i++) begin
      if (i != r.bad_idx) begin
        if (k >= rx_got.size()) abort_run({r.name, " byte missing from RX FIFO"});
        check_byte({r.name, " fifo"}, r.data[31-8*i -: 8], rx_got[k]);
        k++;
      end
    end
    if (k != rx_got.size()) abort_run({r.name, " extra bytes in RX FIFO"});
  endtask

  initial begin
    rst_ni = 1'b0;
    target_enable_i = 1'b1;
    {bus_start_i, bus_rstart_i, bus_stop_i, rx_done_i, tx_done_i} = '0;
    {ccc_done_i, ccc_next_i, tx_fifo_rvalid_i, tx_last_byte_i} = '0;
    rx_fifo_wready_i = 1'b1;
    rx_data_i = '0;
    tx_fifo_rdata_i = '0;
    slot_cfg_i = {S1_DYN, S0_DYN};
    rows[0] = '{"wr_dyn_slot0", {S1_DYN, S0_DYN}, 8'h24, 0, 8'h00, 4, 32'hA53C01FF,
                -1, 0, 0, 0, 8'h00};
    rows[1] = '{"wr_parity", {S1_DYN, S0_DYN}, 8'h24, 0, 8'h00, 3, 32'h11223300,
                1, 0, 0, 0, 8'h00};
    rows[2] = '{"rd_slot1", {S1_DYN, S0_DYN}, 8'h69, 0, 8'h00, 3, 32'hC35A7E00,
                -1, 0, 1, 0, 8'h00};
    rows[3] = '{"nack_nomatch", {S1_DYN, S0_DYN}, 8'h80, 0, 8'h00, 0, 32'h0,
                -1, 1, -1, 0, 8'h00};
    rows[4] = '{"wr_static", {S1_DYN, S0_STA}, 8'hA0, 0, 8'h00, 2, 32'h0FF00000,
                -1, 0, 0, 0, 8'h00};
    rows[5] = '{"none_valid", {S1_DYN, S0_OFF}, 8'hA0, 0, 8'h00, 0, 32'h0,
                -1, 1, -1, 0, 8'h00};
    rows[6] = '{"ccc_code", {S1_DYN, S0_DYN}, 8'hFC, 0, 8'h00, 0, 32'h0,
                -1, 0, -1, 1, 8'h07};
    rows[7] = '{"rsvd_sr_wr", {S1_DYN, S0_DYN}, 8'hFC, 1, 8'h68, 2, 32'h5AA50000,
                -1, 0, 1, 0, 8'h00};
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("reset idle", 1'b1, idle_o);
    check_bit("reset rx req", 1'b0, |rx_req_o);
    check_bit("reset tx req", 1'b0, tx_req_o.req_byte | tx_req_o.req_bit);
    check_bit("reset wvalid", 1'b0, rx_fifo_wvalid_o);
    check_bit("reset rready", 1'b0, tx_fifo_rready_o);
    check_bit("reset ccc valid", 1'b0, ccc_valid_o);
    check_bit("reset nack", 1'b0, event_nack_o);
    check_bit("reset parity", 1'b0, parity_err_o);
    check_bit("reset last addr", 1'b0, last_addr_valid_o);
    foreach (rows[i]) run_row(rows[i]);
    $display("PASS: all tests");
    $finish;
  end

endmodule : tb_i3c_target

//--- src.f
src/i3c_target_pkg.sv
src/i3c_header_decoder.sv
src/i3c_addr_slot.sv
src/i3c_addr_select.sv
src/i3c_target_seq.sv
src/i3c_target_top.sv
bench/i3c_target_assertions.sv
bench/tb_i3c_target.sv

//--- Makefile
# Verilator flow for the I3C target sequencer

VERILATOR ?= verilator
TOP       ?= tb_i3c_target
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  := FAIL: see errors above

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-f $(FILELIST) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "simulation ended without pass"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
